// ==== board_pkg.sv ====
package board_pkg;

    // system bus widths
    localparam int addr_w = 16;
    localparam int data_w = 32;

    // ram depth in words, byte range 0x0000 to 0x0fff
    localparam int ram_words = 1024;

    // peripheral registers at the top of the address space
    localparam logic [addr_w-1:0] led_addr       = 16'hFFFC;
    localparam logic [addr_w-1:0] uart_stat_addr = 16'hFFFD;
    localparam logic [addr_w-1:0] key_addr       = 16'hFFFE;
    localparam logic [addr_w-1:0] uart_data_addr = 16'hFFFF;

    // returned for anything not mapped
    localparam logic [data_w-1:0] bad_word = 32'hDEADBEEF;

    // interrupt vector numbers
    localparam logic [3:0] key_irq_vec = 4'd1;
    localparam logic [3:0] irq_none    = 4'd0;

    // led register after reset
    localparam logic [7:0] led_rst_val = 8'h00;

    // target of one bus access
    typedef enum logic [2:0] {
        reg_ram,
        reg_led,
        reg_uart_stat,
        reg_key,
        reg_uart_data,
        reg_none
    } bus_region_e;

endpackage

// ==== periph_pkg.sv ====
package periph_pkg;

    // 115200 baud from the 50 MHz board clock
    localparam int uart_clks_per_bit = 434;

    // ps2 set 2 break prefix
    localparam logic [7:0] ps2_break_code = 8'hF0;

    // start, 8 data, parity, stop
    localparam int ps2_frame_bits = 11;

    // 8N1 transmitter
    typedef enum logic [1:0] {
        uart_idle,
        uart_start,
        uart_data,
        uart_stop
    } uart_state_e;

    // ps2 frame receiver
    typedef enum logic [1:0] {
        ps2_idle,
        ps2_shift,
        ps2_check
    } ps2_state_e;

endpackage

// ==== key_if.sv ====
interface key_if;

    // last make code seen
    logic [7:0] scan_code;
    // single-cycle event strobes
    logic       key_pressed;
    logic       key_released;
    logic       frame_error;

    // ps2 receiver side
    modport rx (output scan_code, key_pressed, key_released, frame_error);

    // bus side key register
    modport sink (input scan_code, key_pressed, key_released, frame_error);

    // interrupt controller only cares about presses
    modport irq_src (input key_pressed);

endinterface

// ==== ps2_receiver.sv ====
module ps2_receiver (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic ps2_clk,
    input  logic ps2_dat,
    key_if.rx    key
);
    import periph_pkg::*;

    localparam int cnt_w = $clog2(ps2_frame_bits + 1);

    // two flops per line, lines idle high
    logic [1:0]                clk_sync;
    logic [1:0]                dat_sync;
    logic                      clk_prev;
    logic                      clk_fall;

    ps2_state_e                state;
    logic [cnt_w-1:0]          bit_cnt;
    logic [ps2_frame_bits-1:0] frame;
    logic                      frame_good;
    logic [7:0]                code_q;
    logic                      ok_q;
    logic                      bad_q;
    logic                      brk;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // device changes data on rising, we sample on falling
    assign clk_fall = clk_prev & ~clk_sync[1];

    // bits arrive lsb first, so shift in at the top
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && state != ps2_check) begin
            frame <= {dat_sync[1], frame[ps2_frame_bits-1:1]};
        end
    end

    // start low, odd parity over data plus parity, stop high
    assign frame_good = !frame[0]
                     && (^frame[ps2_frame_bits-2:1])
                     && frame[ps2_frame_bits-1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state   <= ps2_idle;
            bit_cnt <= '0;
            ok_q    <= 1'b0;
            bad_q   <= 1'b0;
        end else begin
            ok_q  <= 1'b0;
            bad_q <= 1'b0;
            case (state)
                ps2_idle: begin
                    // first falling edge carries the start bit
                    if (clk_fall) begin
                        bit_cnt <= cnt_w'(1);
                        state   <= ps2_shift;
                    end
                end
                ps2_shift: begin
                    if (clk_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == cnt_w'(ps2_frame_bits - 1)) begin
                            state <= ps2_check;
                        end
                    end
                end
                ps2_check: begin
                    ok_q  <= frame_good;
                    bad_q <= !frame_good;
                    state <= ps2_idle;
                end
                default: state <= ps2_idle;
            endcase
        end
    end

    // data byte sits between start and parity
    always_ff @(posedge CLOCK_50) begin
        if (state == ps2_check) begin
            code_q <= frame[8:1];
        end
    end

    // break tracking stage, F0 arms brk and emits nothing
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            brk              <= 1'b0;
            key.scan_code    <= '0;
            key.key_pressed  <= 1'b0;
            key.key_released <= 1'b0;
            key.frame_error  <= 1'b0;
        end else begin
            key.key_pressed  <= ok_q && code_q != ps2_break_code && !brk;
            key.key_released <= ok_q && code_q != ps2_break_code && brk;
            key.frame_error  <= bad_q;
            if (ok_q) begin
                brk <= (code_q == ps2_break_code);
                if (code_q != ps2_break_code) begin
                    key.scan_code <= code_q;
                end
            end
        end
    end

    // consumers rely on the two strobes being exclusive
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(key.key_pressed && key.key_released));

endmodule

// ==== irq_ctrl.sv ====
module irq_ctrl (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    key_if.irq_src     key,
    input  logic       irq_ack,
    output logic [3:0] irq_vector,
    output logic       irq_pending
);
    import board_pkg::*;

    // one request per press, held until the core acks
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_pending <= 1'b0;
            irq_vector  <= irq_none;
        end else if (key.key_pressed) begin
            // a new press beats a simultaneous ack
            irq_pending <= 1'b1;
            irq_vector  <= key_irq_vec;
        end else if (irq_pending && irq_ack) begin
            irq_pending <= 1'b0;
            irq_vector  <= irq_none;
        end
    end

    // led and vector must agree
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_pending == (irq_vector != irq_none));

endmodule

// ==== uart_tx.sv ====
module uart_tx (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       busy,
    output logic       txd
);
    import periph_pkg::*;

    localparam int baud_w = $clog2(uart_clks_per_bit);

    uart_state_e       state;
    logic [baud_w-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        shreg;
    logic              bit_end;

    // last clock of the current bit
    assign bit_end = (baud_cnt == baud_w'(uart_clks_per_bit - 1));

    // busy rises with the start bit on the line
    assign busy = (state != uart_idle);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= uart_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b1;
        end else begin
            case (state)
                uart_idle: begin
                    baud_cnt <= '0;
                    if (tx_start) begin
                        txd   <= 1'b0;
                        state <= uart_start;
                    end
                end
                uart_start: begin
                    baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    if (bit_end) begin
                        txd     <= shreg[0];
                        bit_cnt <= '0;
                        state   <= uart_data;
                    end
                end
                uart_data: begin
                    baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            txd   <= 1'b1;
                            state <= uart_stop;
                        end else begin
                            txd     <= shreg[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                uart_stop: begin
                    baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    // line already high, just wait out the stop bit
                    if (bit_end) begin
                        state <= uart_idle;
                    end
                end
                default: state <= uart_idle;
            endcase
        end
    end

    // byte captured at start, next lsb moves into bit 0 per bit
    always_ff @(posedge CLOCK_50) begin
        if (state == uart_idle && tx_start) begin
            shreg <= tx_data;
        end else if (bit_end && (state == uart_start || state == uart_data)) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    // a start mid-frame neither restarts nor stalls the bit timer
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        tx_start && busy && !bit_end |=> $stable(state) && baud_cnt == $past(baud_cnt) + 1'b1);

endmodule

// ==== mem_bus_ctrl.sv ====
module mem_bus_ctrl (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic [board_pkg::addr_w-1:0] bus_addr,
    input  logic [board_pkg::data_w-1:0] bus_wdata,
    input  logic                         bus_we,
    input  logic                         bus_re,
    output logic [board_pkg::data_w-1:0] bus_rdata,
    output logic                         bus_rvalid,
    key_if.sink                          key,
    output logic [7:0]                   tx_data,
    output logic                         tx_start,
    input  logic                         tx_busy,
    output logic [7:0]                   leds
);
    import board_pkg::*;

    localparam int idx_w = $clog2(ram_words);

    bus_region_e       region;
    bus_region_e       rd_region;
    logic [idx_w-1:0]  ram_idx;
    logic              rd_fire;
    logic [data_w-1:0] ram [ram_words];
    logic [data_w-1:0] ram_q;
    logic [data_w-1:0] reg_rd;
    logic [data_w-1:0] reg_q;
    logic [7:0]        key_code;
    logic              key_new;

    // ram fills the bottom 4 KB, registers are single addresses
    always_comb begin
        if (bus_addr[addr_w-1:idx_w+2] == '0) begin
            region = reg_ram;
        end else begin
            case (bus_addr)
                led_addr:       region = reg_led;
                uart_stat_addr: region = reg_uart_stat;
                key_addr:       region = reg_key;
                uart_data_addr: region = reg_uart_data;
                default:        region = reg_none;
            endcase
        end
    end

    // word addressed, byte offset ignored
    assign ram_idx = bus_addr[idx_w+1:2];

    // write wins over read
    assign rd_fire = bus_re && !bus_we;

    // register side of the read mux, sampled in the read cycle
    always_comb begin
        case (region)
            reg_led:       reg_rd = {{(data_w-8){1'b0}}, leds};
            reg_uart_stat: reg_rd = {{(data_w-1){1'b0}}, tx_busy};
            reg_key:       reg_rd = {{(data_w-9){1'b0}}, key_new, key_code};
            // uart data is write only
            default:       reg_rd = bad_word;
        endcase
    end

    // block ram, synchronous read
    always_ff @(posedge CLOCK_50) begin
        if (bus_we && region == reg_ram) begin
            ram[ram_idx] <= bus_wdata;
        end
        ram_q <= ram[ram_idx];
        if (rd_fire) begin
            reg_q <= reg_rd;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_rvalid <= 1'b0;
            rd_region  <= reg_none;
            key_new    <= 1'b0;
            key_code   <= '0;
            leds       <= led_rst_val;
        end else begin
            bus_rvalid <= rd_fire;
            if (rd_fire) begin
                rd_region <= region;
            end
            // press sets new, a key read clears it, press wins a tie
            if (key.key_pressed) begin
                key_code <= key.scan_code;
                key_new  <= 1'b1;
            end else if (rd_fire && region == reg_key) begin
                key_new <= 1'b0;
            end
            if (bus_we && region == reg_led) begin
                leds <= bus_wdata[7:0];
            end
        end
    end

    // data phase picks ram or register capture
    assign bus_rdata = (rd_region == reg_ram) ? ram_q : reg_q;

    // writes while busy are dropped here
    assign tx_start = bus_we && region == reg_uart_data && !tx_busy;
    assign tx_data  = bus_wdata[7:0];

    // exactly one data phase per accepted read
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_rvalid |-> $past(rd_fire));

    // releases and bad frames never touch the key register
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        key.key_released || key.frame_error |=> $stable(key_code));

endmodule

// ==== board_top.sv ====
module board_top (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic                         ps2_clk,
    input  logic                         ps2_dat,
    input  logic [board_pkg::addr_w-1:0] bus_addr,
    input  logic [board_pkg::data_w-1:0] bus_wdata,
    input  logic                         bus_we,
    input  logic                         bus_re,
    output logic [board_pkg::data_w-1:0] bus_rdata,
    output logic                         bus_rvalid,
    input  logic                         irq_ack,
    output logic [3:0]                   irq_vector,
    output logic [7:0]                   ledg,
    output logic                         led_irq,
    output logic                         uart_txd
);

    // console link between bus and transmitter
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    // keyboard events
    key_if key ();

    ps2_receiver u_ps2 (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .key      (key.rx)
    );

    // pending flag doubles as the red led
    irq_ctrl u_irq (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key         (key.irq_src),
        .irq_ack     (irq_ack),
        .irq_vector  (irq_vector),
        .irq_pending (led_irq)
    );

    uart_tx u_uart (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .busy     (tx_busy),
        .txd      (uart_txd)
    );

    mem_bus_ctrl u_bus (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_we     (bus_we),
        .bus_re     (bus_re),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .key        (key.sink),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .tx_busy    (tx_busy),
        .leds       (ledg)
    );

endmodule

// ==== tb_board.sv ====
module tb_board;
    timeunit 1ns;
    timeprecision 1ps;

    import board_pkg::*;
    import periph_pkg::*;

    // ps2 half period in board clocks
    localparam int ps2_half = 20;
    // eleven bits plus the idle gap
    localparam int frame_cycles = (ps2_frame_bits + 1) * 2 * ps2_half;
    localparam int uart_byte_cycles = 10 * uart_clks_per_bit;
    // 200 bus accesses, 8 frames, 4 uart bytes, reset, then a quarter on top
    localparam int max_cycles =
        (200 * 4 + 8 * frame_cycles + 4 * uart_byte_cycles + 100) * 5 / 4;

    logic              CLOCK_50;
    logic              KEY0;
    logic              ps2_clk;
    logic              ps2_dat;
    logic [addr_w-1:0] bus_addr;
    logic [data_w-1:0] bus_wdata;
    logic              bus_we;
    logic              bus_re;
    logic [data_w-1:0] bus_rdata;
    logic              bus_rvalid;
    logic              irq_ack;
    logic [3:0]        irq_vector;
    logic [7:0]        ledg;
    logic              led_irq;
    logic              uart_txd;

    // reference model state
    logic [data_w-1:0] ram_m [ram_words];
    logic [7:0]        key_code_m;
    logic              key_new_m;
    logic [7:0]        led_m;
    logic              busy_m;
    logic              irq_m;

    logic [data_w-1:0] exp_q [$];
    logic [7:0]        sent_q [$];
    logic              re_seen;
    logic [15:0]       lfsr;
    int                errors = 0;
    int                cycle = 0;

    board_top board_top_inst (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // what a read of addr must return, given the model state
    function automatic logic [data_w-1:0] expected_read(input logic [addr_w-1:0] addr);
        if (addr[addr_w-1:12] == '0) begin
            return ram_m[addr[11:2]];
        end
        case (addr)
            led_addr:       return {24'h0, led_m};
            uart_stat_addr: return {31'h0, busy_m};
            key_addr:       return {23'h0, key_new_m, key_code_m};
            default:        return bad_word;
        endcase
    endfunction

    task automatic stop_on_error();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    always @(posedge CLOCK_50) begin
        cycle <= cycle + 1;
        if (cycle > max_cycles) begin
            $display("timeout after %0d cycles, a test never finished", cycle);
            stop_on_error();
        end
    end

    // rvalid must follow each accepted read by exactly one cycle
    always @(negedge CLOCK_50) begin
        if (!KEY0) begin
            re_seen <= 1'b0;
        end else begin
            check_value("bus_rvalid", {31'h0, bus_rvalid}, {31'h0, re_seen});
            if (bus_rvalid) begin
                if (exp_q.size() == 0) begin
                    $display("read data returned with no read outstanding");
                    stop_on_error();
                end else begin
                    check_value("bus_rdata", bus_rdata, exp_q.pop_front());
                end
            end
            re_seen <= bus_re && !bus_we;
        end
    end

    task automatic bus_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        @(posedge CLOCK_50);
        bus_addr  <= addr;
        bus_wdata <= data;
        bus_we    <= 1'b1;
        // model follows the write rules
        if (addr[addr_w-1:12] == '0) begin
            ram_m[addr[11:2]] = data;
        end else if (addr == led_addr) begin
            led_m = data[7:0];
        end else if (addr == uart_data_addr && !busy_m) begin
            busy_m = 1'b1;
            sent_q.push_back(data[7:0]);
        end
        @(posedge CLOCK_50);
        bus_we <= 1'b0;
    endtask

    task automatic bus_read(input logic [addr_w-1:0] addr);
        @(posedge CLOCK_50);
        bus_addr <= addr;
        bus_re   <= 1'b1;
        exp_q.push_back(expected_read(addr));
        // key read clears new
        if (addr == key_addr) begin
            key_new_m = 1'b0;
        end
        @(posedge CLOCK_50);
        bus_re <= 1'b0;
        @(posedge CLOCK_50);
    endtask

    // device side of a ps2 frame, lsb first, odd parity
    task automatic ps2_send(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < ps2_frame_bits; i++) begin
            @(posedge CLOCK_50);
            ps2_dat <= bits[i];
            repeat (ps2_half / 2) @(posedge CLOCK_50);
            ps2_clk <= 1'b0;
            repeat (ps2_half) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
            repeat (ps2_half / 2) @(posedge CLOCK_50);
        end
        ps2_dat <= 1'b1;
        // idle gap, strobes are done well before this ends
        repeat (ps2_half) @(posedge CLOCK_50);
    endtask

    task automatic press_key(input logic [7:0] code);
        ps2_send(code, 1'b0);
        key_code_m = code;
        key_new_m  = 1'b1;
        irq_m      = 1'b1;
    endtask

    task automatic ack_irq();
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        irq_m = 1'b0;
    endtask

    task automatic check_irq();
        @(negedge CLOCK_50);
        check_value("irq_vector", {28'h0, irq_vector}, irq_m ? {28'h0, key_irq_vec} : '0);
        check_value("led_irq", {31'h0, led_irq}, {31'h0, irq_m});
    endtask

    // sample mid-bit, then compare against the accepted byte
    task automatic uart_receive();
        logic [7:0] got;
        @(negedge CLOCK_50);
        while (uart_txd !== 1'b0) @(negedge CLOCK_50);
        repeat (uart_clks_per_bit / 2) @(negedge CLOCK_50);
        check_value("uart_txd start", {31'h0, uart_txd}, 32'h0);
        for (int i = 0; i < 8; i++) begin
            repeat (uart_clks_per_bit) @(negedge CLOCK_50);
            got[i] = uart_txd;
        end
        repeat (uart_clks_per_bit) @(negedge CLOCK_50);
        check_value("uart_txd stop", {31'h0, uart_txd}, 32'h1);
        check_value("uart byte", {24'h0, got}, {24'h0, sent_q.pop_front()});
    endtask

    initial begin
        logic [31:0]       rnd;
        logic [addr_w-1:0] ram_addrs [64];
        logic [7:0]        code;
        KEY0       = 1'b0;
        ps2_clk    = 1'b1;
        ps2_dat    = 1'b1;
        bus_addr   = '0;
        bus_wdata  = '0;
        bus_we     = 1'b0;
        bus_re     = 1'b0;
        irq_ack    = 1'b0;
        lfsr       = 16'd49577;
        key_code_m = '0;
        key_new_m  = 1'b0;
        led_m      = 8'h00;
        busy_m     = 1'b0;
        irq_m      = 1'b0;
        repeat (10) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        // values right after reset
        @(negedge CLOCK_50);
        check_value("uart_txd", {31'h0, uart_txd}, 32'h1);
        check_value("ledg", {24'h0, ledg}, 32'h0);
        check_irq();
        bus_read(key_addr);
        bus_read(uart_stat_addr);

        // ram fill and readback
        for (int i = 0; i < 64; i++) begin
            rnd = random_bits(12);
            ram_addrs[i] = rnd[addr_w-1:0];
            bus_write(ram_addrs[i], random_bits(32));
        end
        for (int i = 0; i < 64; i++) begin
            bus_read(ram_addrs[i]);
        end
        bus_read(16'h1000);
        bus_read(16'h8000);
        bus_read(16'hFFFB);

        // press, then read twice to see new clear
        rnd = random_bits(8);
        code = (rnd[7:0] == ps2_break_code) ? 8'h1C : rnd[7:0];
        press_key(code);
        bus_read(key_addr);
        bus_read(key_addr);
        // release sequence leaves the register alone
        ps2_send(ps2_break_code, 1'b0);
        ps2_send(8'h2B, 1'b0);
        bus_read(key_addr);
        check_irq();

        // ack clears the request, so a false press from the bad frame would show
        ack_irq();
        check_irq();
        // corrupted parity is dropped
        ps2_send(8'h33, 1'b1);
        bus_read(key_addr);
        check_irq();

        // interrupt stays clear, then set and clear again
        repeat (50) @(posedge CLOCK_50);
        check_irq();
        press_key(8'h42);
        check_irq();
        ack_irq();
        check_irq();
        repeat (50) @(posedge CLOCK_50);
        check_irq();

        // uart byte, status while busy, dropped second write
        rnd = random_bits(8);
        bus_write(uart_data_addr, {24'h0, rnd[7:0]});
        fork
            uart_receive();
            begin
                bus_read(uart_stat_addr);
                bus_write(uart_data_addr, {24'h0, ~rnd[7:0]});
            end
        join
        repeat (uart_clks_per_bit) @(negedge CLOCK_50);
        busy_m = 1'b0;
        bus_read(uart_stat_addr);
        // line must stay idle for a whole frame
        repeat (uart_byte_cycles) begin
            @(negedge CLOCK_50);
            check_value("uart_txd idle", {31'h0, uart_txd}, 32'h1);
        end

        // led register
        rnd = random_bits(8);
        bus_write(led_addr, {24'h0, rnd[7:0]});
        @(negedge CLOCK_50);
        check_value("ledg", {24'h0, ledg}, {24'h0, led_m});
        bus_read(led_addr);

        if (errors == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_on_error();
        end
    end

endmodule

// ==== compile.f ====
board_pkg.sv
periph_pkg.sv
key_if.sv
ps2_receiver.sv
irq_ctrl.sv
uart_tx.sv
mem_bus_ctrl.sv
board_top.sv
tb_board.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_board -f compile.f

# the testbench decides, the log is searched for its verdict
./obj_dir/Vtb_board > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
    exit 0
fi
exit 1
